//--- include/readout_params.svh
`ifndef READOUT_PARAMS_SVH
`define READOUT_PARAMS_SVH

// data path geometry
`define LANES       5       // samples per clock
`define SAMPLE_W    16
`define PHASE_MOD   50      // phase steps per demod period
`define PHASE_W     6

// widths of the four settings
`define TRIG_W      14
`define LEN_W       11
`define SKIP_W      6
`define FREQ_W      6

`define ACC_W       40
`define AMP         16383   // sine table peak

// AXI4-Lite register map, byte addresses
`define AXI_ADDR_W  8
`define REG_FREQ    8'h00
`define REG_LENGTH  8'h04
`define REG_SKIP    8'h08
`define REG_DELAY   8'h0C

`endif

//--- source/readout_pkg.sv
`include "readout_params.svh"

package readout_pkg;

    ////////////////////
    // samples and phases

    typedef logic signed [`SAMPLE_W-1:0] sample_t;
    typedef logic [`PHASE_W-1:0] phase_t;   // 0 .. PHASE_MOD-1

    ////////////////////
    // settings

    typedef logic [`TRIG_W-1:0] trig_t;
    typedef logic [`LEN_W-1:0] len_t;
    typedef logic [`SKIP_W-1:0] skip_t;
    typedef logic [`FREQ_W-1:0] freq_t;

    ////////////////////
    // rotation results and sums

    typedef logic signed [2*`SAMPLE_W-1:0] prod_t;
    typedef logic signed [`ACC_W-1:0] acc_t;

endpackage

//--- source/readout_regs.sv
`timescale 1ns/1ps
`include "readout_params.svh"

module readout_regs (
    input  logic                    clk100,
    input  logic                    reset,
    // AXI4-Lite slave
    input  logic [`AXI_ADDR_W-1:0]  i_awaddr,
    input  logic                    i_awvalid,
    output logic                    o_awready,
    input  logic [31:0]             i_wdata,
    input  logic                    i_wvalid,
    output logic                    o_wready,
    output logic                    o_bvalid,
    output logic [1:0]              o_bresp,
    input  logic                    i_bready,
    input  logic [`AXI_ADDR_W-1:0]  i_araddr,
    input  logic                    i_arvalid,
    output logic                    o_arready,
    output logic                    o_rvalid,
    output logic [31:0]             o_rdata,
    output logic [1:0]              o_rresp,
    input  logic                    i_rready,
    // settings to the data path
    output readout_pkg::freq_t      o_freq,
    output readout_pkg::len_t       o_length,
    output readout_pkg::skip_t      o_skip,
    output readout_pkg::trig_t      o_delay
);

    logic [31:0] rd_mux;

    assign o_bresp = 2'b00; // always OKAY
    assign o_rresp = 2'b00;

    ////////////////////
    // write channel

    always_ff @(posedge clk100) begin
        if (reset) begin
            o_awready <= 1'b0;
            o_wready  <= 1'b0;
            o_bvalid  <= 1'b0;
            o_freq    <= readout_pkg::freq_t'(5);
            o_length  <= readout_pkg::len_t'(16);
            o_skip    <= readout_pkg::skip_t'(1);
            o_delay   <= readout_pkg::trig_t'(8);
        end else begin
            if (o_awready) begin // address and data taken this edge
                o_awready <= 1'b0;
                o_wready  <= 1'b0;
                o_bvalid  <= 1'b1;
            end else if (i_awvalid && i_wvalid && !o_bvalid) begin
                o_awready <= 1'b1;
                o_wready  <= 1'b1;
                case (i_awaddr)
                    `REG_FREQ:   o_freq   <= i_wdata[`FREQ_W-1:0];
                    `REG_LENGTH: o_length <= i_wdata[`LEN_W-1:0];
                    `REG_SKIP:   o_skip   <= i_wdata[`SKIP_W-1:0];
                    `REG_DELAY:  o_delay  <= i_wdata[`TRIG_W-1:0];
                    default: ;   // outside the map
                endcase
            end
            if (o_bvalid && i_bready)
                o_bvalid <= 1'b0;
        end
    end

    ////////////////////
    // read channel

    always_comb begin
        case (i_araddr)
            `REG_FREQ:   rd_mux = 32'(o_freq);
            `REG_LENGTH: rd_mux = 32'(o_length);
            `REG_SKIP:   rd_mux = 32'(o_skip);
            `REG_DELAY:  rd_mux = 32'(o_delay);
            default:     rd_mux = 32'd0;
        endcase
    end

    always_ff @(posedge clk100) begin
        if (reset) begin
            o_arready <= 1'b0;
            o_rvalid  <= 1'b0;
            o_rdata   <= 32'd0;
        end else begin
            if (o_arready) begin
                o_arready <= 1'b0;
                o_rvalid  <= 1'b1;
            end else if (i_arvalid && !o_rvalid) begin
                o_arready <= 1'b1;
                o_rdata   <= rd_mux; // captured with the address
            end
            if (o_rvalid && i_rready)
                o_rvalid <= 1'b0;
        end
    end

endmodule

//--- source/trigger_delay.sv
`timescale 1ns/1ps

module trigger_delay (
    input  logic                clk100,
    input  logic                reset,
    input  logic                i_trigger,
    input  readout_pkg::trig_t  i_delay,
    input  logic                i_busy,     // window still open in the sampler
    output logic                o_start
);

    logic               counting;
    readout_pkg::trig_t count;
    readout_pkg::trig_t delay_q;

    always_ff @(posedge clk100) begin
        if (reset) begin
            counting <= 1'b0;
            count    <= '0;
            o_start  <= 1'b0;
        end else begin
            o_start <= 1'b0;
            if (counting) begin
                if (count == delay_q) begin
                    counting <= 1'b0;
                    o_start  <= 1'b1;   // single pulse
                end else begin
                    count <= count + 1'b1;
                end
            end else if (i_trigger && !i_busy && !o_start) begin
                counting <= 1'b1;
                count    <= '0;
                delay_q  <= i_delay;
            end
        end
    end

endmodule

//--- source/lane_sampler.sv
`timescale 1ns/1ps
`include "readout_params.svh"

module lane_sampler (
    input  logic                                clk100,
    input  logic                                reset,
    input  logic                                i_start,
    input  readout_pkg::freq_t                  i_freq,
    input  readout_pkg::len_t                   i_length,
    input  readout_pkg::skip_t                  i_skip,
    input  readout_pkg::sample_t [`LANES-1:0]   i_data_i,
    input  readout_pkg::sample_t [`LANES-1:0]   i_data_q,
    output logic                                o_busy,
    output logic                                o_active,
    output logic                                o_last,
    output logic [`LANES-1:0]                   o_take,
    output readout_pkg::phase_t [`LANES-1:0]    o_phase,
    output readout_pkg::sample_t [`LANES-1:0]   o_data_i,
    output readout_pkg::sample_t [`LANES-1:0]   o_data_q
);

    logic                run;        // blocks after the first one
    readout_pkg::len_t   cnt;
    readout_pkg::len_t   len_q;
    readout_pkg::skip_t  skip_q;
    readout_pkg::phase_t step_q;
    readout_pkg::skip_t  offset_q;   // next taken sample, relative to this block
    readout_pkg::phase_t base_q;     // phase of lane 0

    readout_pkg::skip_t  skip_in;
    readout_pkg::phase_t step_in;
    readout_pkg::skip_t  cur_skip;
    readout_pkg::phase_t cur_step;
    logic [7:0]          pos;
    logic [6:0]          ph;
    logic [`LANES-1:0]   take_n;
    readout_pkg::phase_t [`LANES-1:0] phase_n;

    assign o_busy  = run;
    assign skip_in = (i_skip == '0) ? readout_pkg::skip_t'(1) : i_skip;
    assign step_in = (i_freq >= `PHASE_MOD) ? readout_pkg::phase_t'(i_freq - `PHASE_MOD)
                                            : readout_pkg::phase_t'(i_freq);

    // take bits and phases of the current block
    always_comb begin
        cur_skip = run ? skip_q : skip_in;
        cur_step = run ? step_q : step_in;
        pos      = run ? 8'(offset_q) : 8'd0;   // window starts at sample 0, phase 0
        ph       = run ? 7'(base_q) : 7'd0;
        for (int k = 0; k < `LANES; k++) begin
            take_n[k]  = (pos == 8'(k));
            phase_n[k] = ph[`PHASE_W-1:0];
            if (take_n[k])
                pos = pos + 8'(cur_skip);
            ph = ph + 7'(cur_step);
            if (ph >= `PHASE_MOD)
                ph = ph - 7'(`PHASE_MOD);
        end
    end

    always_ff @(posedge clk100) begin
        o_data_i <= i_data_i;
        o_data_q <= i_data_q;
        o_phase  <= phase_n;
        offset_q <= readout_pkg::skip_t'(pos - 8'(`LANES));
        base_q   <= ph[`PHASE_W-1:0];
        if (reset) begin
            run      <= 1'b0;
            cnt      <= '0;
            o_active <= 1'b0;
            o_last   <= 1'b0;
            o_take   <= '0;
        end else if (run || (i_start && i_length != '0)) begin
            o_active <= 1'b1;
            o_take   <= take_n;
            if (!run) begin // first block, settings sampled here
                skip_q <= skip_in;
                step_q <= step_in;
                len_q  <= i_length;
                cnt    <= readout_pkg::len_t'(1);
                run    <= (i_length != readout_pkg::len_t'(1));
                o_last <= (i_length == readout_pkg::len_t'(1));
            end else begin
                cnt    <= cnt + 1'b1;
                run    <= (cnt + 1'b1 != len_q);
                o_last <= (cnt + 1'b1 == len_q);
            end
        end else begin
            o_active <= 1'b0;
            o_last   <= 1'b0;
            o_take   <= '0;
        end
    end

endmodule

//--- source/iq_rotator.sv
`timescale 1ns/1ps
`include "readout_params.svh"

module iq_rotator (
    input  logic                                clk100,
    input  logic                                reset,
    input  logic                                i_active,
    input  logic                                i_last,
    input  logic [`LANES-1:0]                   i_take,
    input  readout_pkg::phase_t [`LANES-1:0]    i_phase,
    input  readout_pkg::sample_t [`LANES-1:0]   i_data_i,
    input  readout_pkg::sample_t [`LANES-1:0]   i_data_q,
    output logic                                o_active,
    output logic                                o_last,
    output readout_pkg::prod_t [`LANES-1:0]     o_rot_i,
    output readout_pkg::prod_t [`LANES-1:0]     o_rot_q
);

    localparam int HALF = `PHASE_MOD / 2;

    logic s1_active;
    logic s1_last;
    readout_pkg::sample_t [`LANES-1:0] s1_sin;
    readout_pkg::sample_t [`LANES-1:0] s1_cos;
    readout_pkg::sample_t [`LANES-1:0] s1_i;
    readout_pkg::sample_t [`LANES-1:0] s1_q;

    ////////////////////
    // quarter tables, steps 0..12 of 50

    function automatic readout_pkg::sample_t sin_qtr(input logic [3:0] idx);
        case (idx)
            4'd0:    sin_qtr = 16'sd0;
            4'd1:    sin_qtr = 16'sd2053;
            4'd2:    sin_qtr = 16'sd4074;
            4'd3:    sin_qtr = 16'sd6031;
            4'd4:    sin_qtr = 16'sd7893;
            4'd5:    sin_qtr = 16'sd9630;
            4'd6:    sin_qtr = 16'sd11215;
            4'd7:    sin_qtr = 16'sd12623;
            4'd8:    sin_qtr = 16'sd13833;
            4'd9:    sin_qtr = 16'sd14824;
            4'd10:   sin_qtr = 16'sd15581;
            4'd11:   sin_qtr = 16'sd16093;
            default: sin_qtr = 16'sd16351;
        endcase
    endfunction

    function automatic readout_pkg::sample_t cos_qtr(input logic [3:0] idx);
        case (idx)
            4'd0:    cos_qtr = readout_pkg::sample_t'(`AMP);
            4'd1:    cos_qtr = 16'sd16254;
            4'd2:    cos_qtr = 16'sd15868;
            4'd3:    cos_qtr = 16'sd15233;
            4'd4:    cos_qtr = 16'sd14357;
            4'd5:    cos_qtr = 16'sd13254;
            4'd6:    cos_qtr = 16'sd11943;
            4'd7:    cos_qtr = 16'sd10443;
            4'd8:    cos_qtr = 16'sd8778;
            4'd9:    cos_qtr = 16'sd6976;
            4'd10:   cos_qtr = 16'sd5063;
            4'd11:   cos_qtr = 16'sd3070;
            default: cos_qtr = 16'sd1029;
        endcase
    endfunction

    // sin(p + 25) = -sin(p), sin(25 - p) = sin(p)
    function automatic readout_pkg::sample_t lut_sin(input readout_pkg::phase_t p);
        logic [5:0] q;
        q = (p >= HALF) ? p - 6'(HALF) : p;
        if (q > 6'd12)
            q = 6'(HALF) - q;
        lut_sin = (p >= HALF) ? -sin_qtr(q[3:0]) : sin_qtr(q[3:0]);
    endfunction

    // cos(50 - p) = cos(p), cos(25 - p) = -cos(p)
    function automatic readout_pkg::sample_t lut_cos(input readout_pkg::phase_t p);
        logic [5:0] r;
        logic [5:0] m;
        r = (p > HALF) ? 6'(`PHASE_MOD) - p : p;
        m = 6'(HALF) - r;
        lut_cos = (r > 6'd12) ? -cos_qtr(m[3:0]) : cos_qtr(r[3:0]);
    endfunction

    ////////////////////
    // stage 1 lookup, stage 2 multiply

    always_ff @(posedge clk100) begin
        for (int k = 0; k < `LANES; k++) begin
            s1_sin[k] <= lut_sin(i_phase[k]);
            s1_cos[k] <= lut_cos(i_phase[k]);
            s1_i[k]   <= i_take[k] ? i_data_i[k] : '0;  // skipped lanes add nothing
            s1_q[k]   <= i_take[k] ? i_data_q[k] : '0;
            o_rot_i[k] <= s1_i[k] * s1_cos[k] + s1_q[k] * s1_sin[k];
            o_rot_q[k] <= s1_q[k] * s1_cos[k] - s1_i[k] * s1_sin[k];
        end
        if (reset) begin
            s1_active <= 1'b0;
            s1_last   <= 1'b0;
            o_active  <= 1'b0;
            o_last    <= 1'b0;
        end else begin
            s1_active <= i_active;
            s1_last   <= i_last;
            o_active  <= s1_active;
            o_last    <= s1_last;
        end
    end

endmodule

//--- source/iq_integrator.sv
`timescale 1ns/1ps
`include "readout_params.svh"

module iq_integrator (
    input  logic                            clk100,
    input  logic                            reset,
    input  logic                            i_active,
    input  logic                            i_last,
    input  readout_pkg::prod_t [`LANES-1:0] i_rot_i,
    input  readout_pkg::prod_t [`LANES-1:0] i_rot_q,
    output logic                            o_iq_valid,
    output readout_pkg::acc_t               o_i_total,
    output readout_pkg::acc_t               o_q_total
);

    logic              in_win;  // past the first block of a window
    readout_pkg::acc_t acc_i;
    readout_pkg::acc_t acc_q;
    readout_pkg::acc_t sum_i;
    readout_pkg::acc_t sum_q;

    // five lanes plus the running total
    always_comb begin
        sum_i = in_win ? acc_i : '0;
        sum_q = in_win ? acc_q : '0;
        for (int k = 0; k < `LANES; k++) begin
            sum_i = sum_i + readout_pkg::acc_t'(i_rot_i[k]);
            sum_q = sum_q + readout_pkg::acc_t'(i_rot_q[k]);
        end
    end

    always_ff @(posedge clk100) begin
        if (reset) begin
            in_win     <= 1'b0;
            o_iq_valid <= 1'b0;
            o_i_total  <= '0;
            o_q_total  <= '0;
        end else begin
            o_iq_valid <= i_active && i_last;
            if (i_active) begin
                acc_i  <= sum_i;
                acc_q  <= sum_q;
                in_win <= !i_last;
                if (i_last) begin   // totals hold until the next window
                    o_i_total <= sum_i;
                    o_q_total <= sum_q;
                end
            end
        end
    end

endmodule

//--- source/readout_top.sv
`timescale 1ns/1ps
`include "readout_params.svh"

module readout_top (
    input  logic                                clk100,
    input  logic                                reset,
    // AXI4-Lite
    input  logic [`AXI_ADDR_W-1:0]              i_awaddr,
    input  logic                                i_awvalid,
    output logic                                o_awready,
    input  logic [31:0]                         i_wdata,
    input  logic                                i_wvalid,
    output logic                                o_wready,
    output logic                                o_bvalid,
    output logic [1:0]                          o_bresp,
    input  logic                                i_bready,
    input  logic [`AXI_ADDR_W-1:0]              i_araddr,
    input  logic                                i_arvalid,
    output logic                                o_arready,
    output logic                                o_rvalid,
    output logic [31:0]                         o_rdata,
    output logic [1:0]                          o_rresp,
    input  logic                                i_rready,
    // data path
    input  logic                                i_trigger,
    input  readout_pkg::sample_t [`LANES-1:0]   i_data_i,
    input  readout_pkg::sample_t [`LANES-1:0]   i_data_q,
    output logic                                o_iq_valid,
    output readout_pkg::acc_t                   o_i_total,
    output readout_pkg::acc_t                   o_q_total
);

    readout_pkg::freq_t freq;
    readout_pkg::len_t  length;
    readout_pkg::skip_t skip;
    readout_pkg::trig_t delay;

    logic start;
    logic busy;
    logic smp_active;
    logic smp_last;
    logic [`LANES-1:0] smp_take;
    readout_pkg::phase_t [`LANES-1:0]  smp_phase;
    readout_pkg::sample_t [`LANES-1:0] smp_i;
    readout_pkg::sample_t [`LANES-1:0] smp_q;
    logic rot_active;
    logic rot_last;
    readout_pkg::prod_t [`LANES-1:0] rot_i;
    readout_pkg::prod_t [`LANES-1:0] rot_q;

    readout_regs u_regs (
        .clk100, .reset,
        .i_awaddr, .i_awvalid, .o_awready, .i_wdata, .i_wvalid, .o_wready,
        .o_bvalid, .o_bresp, .i_bready,
        .i_araddr, .i_arvalid, .o_arready, .o_rvalid, .o_rdata, .o_rresp, .i_rready,
        .o_freq(freq), .o_length(length), .o_skip(skip), .o_delay(delay)
    );

    trigger_delay u_delay (
        .clk100, .reset, .i_trigger,
        .i_delay(delay), .i_busy(busy), .o_start(start)
    );

    lane_sampler u_sampler (
        .clk100, .reset, .i_start(start),
        .i_freq(freq), .i_length(length), .i_skip(skip),
        .i_data_i, .i_data_q,
        .o_busy(busy), .o_active(smp_active), .o_last(smp_last),
        .o_take(smp_take), .o_phase(smp_phase), .o_data_i(smp_i), .o_data_q(smp_q)
    );

    iq_rotator u_rotator (
        .clk100, .reset,
        .i_active(smp_active), .i_last(smp_last), .i_take(smp_take),
        .i_phase(smp_phase), .i_data_i(smp_i), .i_data_q(smp_q),
        .o_active(rot_active), .o_last(rot_last), .o_rot_i(rot_i), .o_rot_q(rot_q)
    );

    iq_integrator u_integrator (
        .clk100, .reset,
        .i_active(rot_active), .i_last(rot_last), .i_rot_i(rot_i), .i_rot_q(rot_q),
        .o_iq_valid, .o_i_total, .o_q_total
    );

endmodule

//--- tests/readout_checker.sv
`timescale 1ns/1ps
`include "readout_params.svh"

module readout_checker (
    input  logic                                clk100,
    input  logic                                reset,
    input  logic                                i_trigger,
    input  readout_pkg::sample_t [`LANES-1:0]   i_data_i,
    input  readout_pkg::sample_t [`LANES-1:0]   i_data_q,
    input  logic [`AXI_ADDR_W-1:0]              i_awaddr,
    input  logic                                i_awvalid,
    input  logic                                i_awready,
    input  logic [31:0]                         i_wdata,
    input  logic                                i_wready,
    input  logic                                i_bvalid,
    input  logic [1:0]                          i_bresp,
    input  logic [`AXI_ADDR_W-1:0]              i_araddr,
    input  logic                                i_arvalid,
    input  logic                                i_arready,
    input  logic                                i_rvalid,
    input  logic                                i_rready,
    input  logic [31:0]                         i_rdata,
    input  logic [1:0]                          i_rresp,
    input  logic                                i_iq_valid,
    input  readout_pkg::acc_t                   i_i_total,
    input  readout_pkg::acc_t                   i_q_total,
    output int                                  o_value_errs,
    output int                                  o_event_errs,
    output int                                  o_pending
);

    localparam real PI = 3.14159265358979;

    logic [31:0] sh_freq;       // register contents as written over AXI
    logic [31:0] sh_length;
    logic [31:0] sh_skip;
    logic [31:0] sh_delay;
    logic [`AXI_ADDR_W-1:0] rd_addr;
    logic [`ACC_W-1:0] held_i;
    logic [`ACC_W-1:0] held_q;
    longint cyc = 0;
    longint start_at;
    longint busy_until;
    logic win_on;
    int blk;
    int w_freq;
    int w_skip;
    int w_len;
    longint acc_i;
    longint acc_q;
    longint exp_cyc[$];
    longint exp_i[$];
    longint exp_q[$];

    function automatic longint table_sin(input longint p);
        real x;
        x = `AMP * $sin(2.0 * PI * p / `PHASE_MOD);
        return longint'(x);     // rounds to nearest
    endfunction

    function automatic longint table_cos(input longint p);
        real x;
        x = `AMP * $cos(2.0 * PI * p / `PHASE_MOD);
        return longint'(x);
    endfunction

    function automatic logic [31:0] reg_value(input logic [`AXI_ADDR_W-1:0] a);
        case (a)
            `REG_FREQ:   return sh_freq;
            `REG_LENGTH: return sh_length;
            `REG_SKIP:   return sh_skip;
            `REG_DELAY:  return sh_delay;
            default:     return 32'd0;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [`ACC_W-1:0] exp_v,
                                   input logic [`ACC_W-1:0] got_v);
        $display("ERR %s expected %h actual %h", name, exp_v, got_v);
        o_value_errs++;
    endtask

    always @(posedge clk100) begin
        longint n;
        longint p;
        longint di;
        longint dq;
        longint s;
        longint c;
        if (reset) begin
            sh_freq    = 32'd5;
            sh_length  = 32'd16;
            sh_skip    = 32'd1;
            sh_delay   = 32'd8;
            win_on     = 1'b0;
            start_at   = -1;
            busy_until = -1;
            held_i     = '0;
            held_q     = '0;
            exp_cyc.delete();
            exp_i.delete();
            exp_q.delete();
        end else begin
            ////////////////////
            // register shadow and read data

            if (i_awvalid && i_awready) begin
                case (i_awaddr)
                    `REG_FREQ:   sh_freq   = 32'(i_wdata[`FREQ_W-1:0]);
                    `REG_LENGTH: sh_length = 32'(i_wdata[`LEN_W-1:0]);
                    `REG_SKIP:   sh_skip   = 32'(i_wdata[`SKIP_W-1:0]);
                    `REG_DELAY:  sh_delay  = 32'(i_wdata[`TRIG_W-1:0]);
                    default: ;
                endcase
            end
            if (i_wready !== i_awready)     // both readies rise together
                report_mismatch("o_wready", 40'(i_awready), 40'(i_wready));
            if (i_bvalid && i_bresp !== 2'b00)  // OKAY only
                report_mismatch("o_bresp", 40'd0, 40'(i_bresp));
            if (i_rvalid && i_rresp !== 2'b00)
                report_mismatch("o_rresp", 40'd0, 40'(i_rresp));
            if (i_arvalid && i_arready)
                rd_addr = i_araddr;
            if (i_rvalid && i_rready && i_rdata !== reg_value(rd_addr))
                report_mismatch("o_rdata", 40'(reg_value(rd_addr)), 40'(i_rdata));

            ////////////////////
            // window model

            if (cyc == start_at) begin  // settings taken at window start
                win_on     = 1'b1;
                blk        = 0;
                acc_i      = 0;
                acc_q      = 0;
                w_freq     = sh_freq;
                w_skip     = sh_skip;
                w_len      = sh_length;
                busy_until = cyc + w_len - 1;
            end
            if (win_on) begin
                for (int k = 0; k < `LANES; k++) begin
                    n = blk * `LANES + k;
                    if (n % w_skip == 0) begin
                        p  = (n * w_freq) % `PHASE_MOD;
                        s  = table_sin(p);
                        c  = table_cos(p);
                        di = longint'($signed(i_data_i[k]));
                        dq = longint'($signed(i_data_q[k]));
                        acc_i += di * c + dq * s;
                        acc_q += dq * c - di * s;
                    end
                end
                blk++;
                if (blk == w_len) begin
                    win_on = 1'b0;
                    exp_cyc.push_back(cyc + 4);     // sampler, rotator, integrator
                    exp_i.push_back(acc_i);
                    exp_q.push_back(acc_q);
                end
            end
            if (i_trigger && cyc > busy_until) begin
                start_at   = cyc + sh_delay + 2;   // start seen two edges after delay
                busy_until = start_at;
            end

            ////////////////////
            // results

            if (i_iq_valid) begin
                if (exp_cyc.size() > 0 && exp_cyc[0] == cyc) begin
                    if (i_i_total !== 40'(exp_i[0]))
                        report_mismatch("o_i_total", 40'(exp_i[0]), i_i_total);
                    if (i_q_total !== 40'(exp_q[0]))
                        report_mismatch("o_q_total", 40'(exp_q[0]), i_q_total);
                    void'(exp_cyc.pop_front());
                    void'(exp_i.pop_front());
                    void'(exp_q.pop_front());
                end else begin
                    $display("valid pulse at cycle %0d with no result due", cyc);
                    o_event_errs++;
                end
                held_i = i_i_total;
                held_q = i_q_total;
            end else begin
                if (exp_cyc.size() > 0 && exp_cyc[0] == cyc) begin
                    $display("result due at cycle %0d but valid stayed low", cyc);
                    o_event_errs++;
                    void'(exp_cyc.pop_front());
                    void'(exp_i.pop_front());
                    void'(exp_q.pop_front());
                end
                if (i_i_total !== held_i)   // totals hold between results
                    report_mismatch("o_i_total", held_i, i_i_total);
                if (i_q_total !== held_q)
                    report_mismatch("o_q_total", held_q, i_q_total);
            end
            o_pending = exp_cyc.size();
        end
        cyc++;
    end

endmodule

//--- tests/tb_readout.sv
`timescale 1ns/1ps
`include "readout_params.svh"

module tb_readout;

    localparam int NCASE = 6;

    logic clk100 = 1'b0;
    logic reset;
    logic [`AXI_ADDR_W-1:0] awaddr;
    logic awvalid;
    logic awready;
    logic [31:0] wdata;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic [1:0] bresp;
    logic bready;
    logic [`AXI_ADDR_W-1:0] araddr;
    logic arvalid;
    logic arready;
    logic rvalid;
    logic [31:0] rdata;
    logic [1:0] rresp;
    logic rready;
    logic trigger;
    readout_pkg::sample_t [`LANES-1:0] data_i = '0;
    readout_pkg::sample_t [`LANES-1:0] data_q = '0;
    logic iq_valid;
    readout_pkg::acc_t i_total;
    readout_pkg::acc_t q_total;
    int value_errs;
    int event_errs;
    int pending;
    logic [15:0] lfsr = 16'd3921;
    int cycles = 0;
    int limit;

    ////////////////////
    // acquisition cases

    int t_freq   [NCASE] = '{5, 7, 13, 3, 11, 49};
    int t_skip   [NCASE] = '{1, 2, 3, 7, 12, 1};
    int t_len    [NCASE] = '{16, 20, 17, 24, 30, 1};
    int t_delay  [NCASE] = '{8, 3, 12, 5, 1, 20};
    int t_retrig [NCASE] = '{0, 0, 1, 0, 1, 0};    // second trigger inside the window
    int t_late   [NCASE] = '{0, 0, 0, 1, 0, 0};    // frequency rewrite inside the window

    always #50 clk100 = ~clk100;

    readout_top i_dut (
        .clk100(clk100), .reset(reset),
        .i_awaddr(awaddr), .i_awvalid(awvalid), .o_awready(awready),
        .i_wdata(wdata), .i_wvalid(wvalid), .o_wready(wready),
        .o_bvalid(bvalid), .o_bresp(bresp), .i_bready(bready),
        .i_araddr(araddr), .i_arvalid(arvalid), .o_arready(arready),
        .o_rvalid(rvalid), .o_rdata(rdata), .o_rresp(rresp), .i_rready(rready),
        .i_trigger(trigger), .i_data_i(data_i), .i_data_q(data_q),
        .o_iq_valid(iq_valid), .o_i_total(i_total), .o_q_total(q_total)
    );

    readout_checker i_check (
        .clk100(clk100), .reset(reset), .i_trigger(trigger),
        .i_data_i(data_i), .i_data_q(data_q),
        .i_awaddr(awaddr), .i_awvalid(awvalid), .i_awready(awready), .i_wdata(wdata),
        .i_wready(wready), .i_bvalid(bvalid), .i_bresp(bresp),
        .i_araddr(araddr), .i_arvalid(arvalid), .i_arready(arready),
        .i_rvalid(rvalid), .i_rready(rready), .i_rdata(rdata), .i_rresp(rresp),
        .i_iq_valid(iq_valid), .i_i_total(i_total), .i_q_total(q_total),
        .o_value_errs(value_errs), .o_event_errs(event_errs), .o_pending(pending)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // new sample block every clock, one LFSR step per bit
    always @(posedge clk100) begin : drive_samples
        logic [15:0] word_i;
        logic [15:0] word_q;
        for (int k = 0; k < `LANES; k++) begin
            for (int b = 0; b < 16; b++) begin
                word_i[b] = lfsr[0];
                lfsr = lfsr_next(lfsr);
            end
            for (int b = 0; b < 16; b++) begin
                word_q[b] = lfsr[0];
                lfsr = lfsr_next(lfsr);
            end
            data_i[k] <= word_i;
            data_q[k] <= word_q;
        end
    end

    always @(posedge clk100) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout after %0d cycles without finishing the case table", cycles);
            $display("sim failed");
            $finish;
        end
    end

    ////////////////////
    // bus and trigger tasks, entered on a clock edge

    task automatic axi_write(input logic [`AXI_ADDR_W-1:0] addr, input logic [31:0] data);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(posedge clk100); while (!awready);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(posedge clk100); while (!bvalid);
    endtask

    task automatic axi_read(input logic [`AXI_ADDR_W-1:0] addr);
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(posedge clk100); while (!arready);
        arvalid <= 1'b0;
        do @(posedge clk100); while (!rvalid);  // data compared in the checker
    endtask

    task automatic read_settings();
        axi_read(`REG_FREQ);
        axi_read(`REG_LENGTH);
        axi_read(`REG_SKIP);
        axi_read(`REG_DELAY);
        axi_read(8'h10);    // outside the map
    endtask

    task automatic pulse_trigger();
        trigger <= 1'b1;
        @(posedge clk100);
        trigger <= 1'b0;
    endtask

    task automatic run_case(input int c);
        axi_write(`REG_FREQ, 32'hA5A5_0000 | 32'(t_freq[c]));
        axi_write(`REG_LENGTH, 32'hA5A5_0000 | 32'(t_len[c]));
        axi_write(`REG_SKIP, 32'hA5A5_0000 | 32'(t_skip[c]));
        axi_write(`REG_DELAY, 32'hA5A5_0000 | 32'(t_delay[c]));
        read_settings();
        pulse_trigger();
        if (t_late[c] != 0) begin
            repeat (t_delay[c] + 3) @(posedge clk100);
            axi_write(`REG_FREQ, 32'(t_freq[c] + 1));
        end
        if (t_retrig[c] != 0) begin
            repeat (t_delay[c] + 4) @(posedge clk100);
            pulse_trigger();
        end
        do @(posedge clk100); while (!iq_valid);
    endtask

    initial begin
        reset   = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        trigger = 1'b0;
        limit   = 200;
        for (int c = 0; c < NCASE; c++)
            limit += t_delay[c] + t_len[c] + 40 + 60;  // 60 for the case's bus traffic

        repeat (16) @(posedge clk100);
        reset  <= 1'b0;
        bready <= 1'b1;
        rready <= 1'b1;
        @(posedge clk100);

        read_settings();    // defaults
        axi_write(`REG_FREQ, 32'hFFFF_FFC5);
        axi_write(`REG_LENGTH, 32'hFFFF_F810);
        axi_write(`REG_SKIP, 32'hFFFF_FFC1);
        axi_write(`REG_DELAY, 32'hFFFF_C008);
        axi_write(8'h10, 32'hFFFF_FFFF);
        read_settings();

        for (int c = 0; c < NCASE; c++)
            run_case(c);
        repeat (30) @(posedge clk100);  // room for a stray valid

        $display("errors: %0d value, %0d event, %0d results never seen",
                 value_errs, event_errs, pending);
        if (value_errs == 0 && event_errs == 0 && pending == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+include
source/readout_pkg.sv
source/readout_regs.sv
source/trigger_delay.sv
source/lane_sampler.sv
source/iq_rotator.sv
source/iq_integrator.sv
source/readout_top.sv
tests/readout_checker.sv
tests/tb_readout.sv
